//--- ntt_pkg.sv
// constants, types and twiddle table shared by the ntt engine
// modules pull this in with a wildcard import in their header
`default_nettype none

package ntt_pkg;

    // --------------------------------------------------
    // modulus and montgomery constants, R = 2^16
    // --------------------------------------------------
    localparam logic [15:0] NTT_Q    = 16'd12289;
    // -q^-1 mod 2^16
    localparam logic [15:0] NTT_QINV = 16'd12287;

    // --------------------------------------------------
    // transform geometry
    // --------------------------------------------------
    localparam int NTT_N      = 128;
    localparam int NTT_LANES  = 8;
    localparam int NTT_STAGES = 7;
    localparam int NTT_STEPS  = NTT_N / (2 * NTT_LANES);
    localparam int NTT_WORDS  = 16;
    localparam int NIBBLE_W   = 4;

    typedef logic [15:0] coeff_t;
    typedef logic [13:0] twiddle_t;
    typedef logic [31:0] in_word_t;
    typedef logic [6:0]  coeff_idx_t;

    // one bank row, lane 0 in the low bits
    typedef coeff_t [NTT_LANES-1:0] coeff_row_t;

    // --------------------------------------------------
    // bit-reversed twiddles in montgomery form
    // stage s, group g uses entry 2^s + g, entry 0 unused
    // --------------------------------------------------
    localparam twiddle_t NTT_TWIDDLES [NTT_N] = '{
            0,  7888, 11060, 11208,  6960,  4342,  6275,  9759,
         1591,  6399,  9477,  5266,   586,  5825,  7538,  9710,
         1134,  6407,  1711,   965,  7099,  7674,  3743,  6442,
        10414,  8100,  1885,  1688,  1364, 10329, 10164,  9180,
        12210,  6240,   997,   117,  4783,  4407,  1549,  7072,
         2829,  6458,  4431,  8877,  7144,  2564,  5664,  4042,
        12189,   432, 10751,  1237,  7610,  1534,  3983,  7863,
         2181,  6308,  8720,  6570,  4843,  1690,    14,  3872,
         5569,  9368, 12163,  2019,  7543,  2315,  4673,  7340,
         1553,  1156,  8401, 11389,  1020,  2967, 10772,  7045,
         3316, 11236,  5285, 11578, 10637, 10086,  9493,  6180,
         9277,  6130,  3323,   883, 10469,   489,  1502,  2851,
        11061,  9729,  2742, 12241,  4970, 10481, 10078,  1195,
          730,  1762,  3854,  2030,  5892, 10922,  9020,  5274,
         9179,  3604,  3782, 10206,  3180,  3467,  4668,  2446,
         7613,  9386,   834,  7703,  6836,  3403,  5351, 12276
    };

endpackage

`default_nettype wire

//--- ntt_load_if.sv
// row load channel from the input unpacker into the coefficient bank
`default_nettype none

interface ntt_load_if import ntt_pkg::*; ();

    logic       wr_en;
    logic       wr_last;
    coeff_row_t wr_row;
    // bank can take rows
    logic       ready;

    modport decode_mp (output wr_en, output wr_last, output wr_row, input ready);

    modport execute_mp (input wr_en, input wr_last, input wr_row, output ready);

endinterface

`default_nettype wire

//--- ntt_drain_if.sv
// handoff of a finished frame from the butterfly core to the output drainer
`default_nettype none

interface ntt_drain_if import ntt_pkg::*; ();

    logic       start;
    logic       finished;
    coeff_idx_t rd_addr;
    // combinational bank read at rd_addr
    coeff_t     rd_data;

    modport execute_mp (output start, output rd_data, input rd_addr, input finished);

    modport result_mp (input start, input rd_data, output rd_addr, output finished);

endinterface

`default_nettype wire

//--- ntt_decode.sv
// input unpacker: takes 32-bit words while the core is ready and turns
// each one into a row of eight zero-extended nibble coefficients
`default_nettype none

module ntt_decode import ntt_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  in_word_t in_data,
    output logic     busy,
    ntt_load_if.decode_mp load
);

    localparam int CNT_W = $clog2(NTT_WORDS);

    logic             accept;
    logic [CNT_W-1:0] word_cnt;

    assign accept = in_valid && load.ready;
    assign busy   = ~load.ready;

    // --------------------------------------------------
    // word counter and row strobes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt     <= '0;
            load.wr_en   <= 1'b0;
            load.wr_last <= 1'b0;
        end else begin
            load.wr_en   <= accept;
            load.wr_last <= accept && (word_cnt == CNT_W'(NTT_WORDS - 1));
            if (accept) begin
                if (word_cnt == CNT_W'(NTT_WORDS - 1)) begin
                    word_cnt <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // nibble l of the word becomes lane l
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int l = 0; l < NTT_LANES; l++) begin
                load.wr_row[l] <= coeff_t'(in_data[l*NIBBLE_W +: NIBBLE_W]);
            end
        end
    end

endmodule

`default_nettype wire

//--- ntt_butterfly.sv
// one cooley-tukey butterfly mod q, purely combinational
// b is scaled by a montgomery-form twiddle, so the product leaves R behind
`default_nettype none

module ntt_butterfly import ntt_pkg::*; (
    input  coeff_t   a,
    input  coeff_t   b,
    input  twiddle_t w,
    output coeff_t   res_a,
    output coeff_t   res_b
);

    logic [29:0] prod;
    logic [15:0] red_k;
    logic [31:0] red_sum;
    logic [15:0] red_hi;
    coeff_t      m;
    logic [16:0] sum;

    // montgomery reduction of b*w
    assign prod    = b * w;
    assign red_k   = prod[15:0] * NTT_QINV;
    assign red_sum = {2'b00, prod} + red_k * NTT_Q;
    // low half is zero by construction
    assign red_hi  = red_sum[31:16];

    // red_hi < 2q here, one subtract is enough
    assign m = (red_hi >= NTT_Q) ? red_hi - NTT_Q : red_hi;

    assign sum   = {1'b0, a} + {1'b0, m};
    assign res_a = (sum >= {1'b0, NTT_Q}) ? coeff_t'(sum - {1'b0, NTT_Q}) : coeff_t'(sum);
    assign res_b = (a >= m) ? a - m : (a + NTT_Q) - m;

endmodule

`default_nettype wire

//--- ntt_execute.sv
// butterfly core: 128-entry coefficient bank, load shifting, and the
// 7-stage x 8-step schedule driving eight parallel butterflies
// results are read out through the drain channel after the last stage
`default_nettype none

module ntt_execute import ntt_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    ntt_load_if.execute_mp  load,
    ntt_drain_if.execute_mp drain
);

    localparam int IDX_W   = $clog2(NTT_N);
    localparam int LANE_W  = $clog2(NTT_LANES);
    localparam int STAGE_W = $clog2(NTT_STAGES);
    localparam int STEP_W  = $clog2(NTT_STEPS);

    typedef enum logic [1:0] {
        S_LOAD,
        S_COMPUTE,
        S_DRAIN
    } state_t;

    state_t              state;
    logic [STAGE_W-1:0]  stage;
    logic [STEP_W-1:0]   step;
    logic                last_step;
    coeff_t              bank [NTT_N];

    coeff_idx_t          half;
    coeff_idx_t          idx_a  [NTT_LANES];
    coeff_idx_t          idx_b  [NTT_LANES];
    coeff_idx_t          tw_idx [NTT_LANES];
    coeff_t              res_a  [NTT_LANES];
    coeff_t              res_b  [NTT_LANES];

    assign last_step = (stage == STAGE_W'(NTT_STAGES - 1)) &&
                       (step == STEP_W'(NTT_STEPS - 1));

    // stall the unpacker once the last row is on the wire
    assign load.ready = (state == S_LOAD) && !(load.wr_en && load.wr_last);

    assign drain.rd_data = bank[drain.rd_addr];

    // --------------------------------------------------
    // address and twiddle generation
    // --------------------------------------------------
    // half distance d = 64 >> stage
    assign half = coeff_idx_t'(NTT_N / 2) >> stage;

    for (genvar l = 0; l < NTT_LANES; l++) begin : g_lane
        coeff_idx_t j;
        coeff_idx_t grp;

        // butterfly j = 8*step + lane, grp = j / d
        assign j   = coeff_idx_t'({step, LANE_W'(l)});
        assign grp = j >> (IDX_W - 1 - stage);

        // a = 2d*grp + (j mod d), b = a + d
        assign idx_a[l]  = (grp << (IDX_W - stage)) | (j & (half - 1'b1));
        assign idx_b[l]  = idx_a[l] + half;
        assign tw_idx[l] = (coeff_idx_t'(1) << stage) + grp;

        ntt_butterfly u_bfly (
            .a     (bank[idx_a[l]]),
            .b     (bank[idx_b[l]]),
            .w     (NTT_TWIDDLES[tw_idx[l]]),
            .res_a (res_a[l]),
            .res_b (res_b[l])
        );
    end

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_LOAD;
            stage       <= '0;
            step        <= '0;
            drain.start <= 1'b0;
        end else begin
            drain.start <= 1'b0;
            case (state)
                S_LOAD: begin
                    if (load.wr_en && load.wr_last) begin
                        state <= S_COMPUTE;
                        stage <= '0;
                        step  <= '0;
                    end
                end
                S_COMPUTE: begin
                    // one step per cycle, stage rolls after the eighth
                    step <= step + 1'b1;
                    if (step == STEP_W'(NTT_STEPS - 1)) begin
                        stage <= stage + 1'b1;
                    end
                    if (last_step) begin
                        state       <= S_DRAIN;
                        drain.start <= 1'b1;
                    end
                end
                S_DRAIN: begin
                    if (drain.finished) begin
                        state <= S_LOAD;
                    end
                end
                default: begin
                    state <= S_LOAD;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // coefficient bank
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == S_LOAD && load.wr_en) begin
            // rows enter at the top, word k lands at 8k..8k+7
            for (int i = 0; i < NTT_N - NTT_LANES; i++) begin
                bank[i] <= bank[i + NTT_LANES];
            end
            for (int l = 0; l < NTT_LANES; l++) begin
                bank[NTT_N - NTT_LANES + l] <= load.wr_row[l];
            end
        end else if (state == S_COMPUTE) begin
            // in-place write back, pairs never collide within a step
            for (int l = 0; l < NTT_LANES; l++) begin
                bank[idx_a[l]] <= res_a[l];
                bank[idx_b[l]] <= res_b[l];
            end
        end
    end

endmodule

`default_nettype wire

//--- ntt_result.sv
// output drainer: walks the finished bank in index order and sends one
// coefficient per cycle as long as the consumer has granted credits
`default_nettype none

module ntt_result import ntt_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    ntt_drain_if.result_mp drain,
    input  logic   credit_return,
    output logic   out_valid,
    output coeff_t out_data
);

    localparam int CRED_W = $clog2(CREDITS + 1);

    logic              active;
    logic              send;
    coeff_idx_t        addr;
    logic [CRED_W-1:0] credits;

    // never spend a credit we do not hold
    assign send          = active && (credits != '0);
    assign drain.rd_addr = addr;

    // --------------------------------------------------
    // drain sequencing and credit count
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active         <= 1'b0;
            addr           <= '0;
            credits        <= CRED_W'(CREDITS);
            out_valid      <= 1'b0;
            drain.finished <= 1'b0;
        end else begin
            out_valid      <= send;
            drain.finished <= send && (addr == coeff_idx_t'(NTT_N - 1));

            if (drain.start) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (send) begin
                addr <= addr + 1'b1;
                if (addr == coeff_idx_t'(NTT_N - 1)) begin
                    active <= 1'b0;
                end
            end

            // spend and return may land in the same cycle
            if (send && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!send && credit_return) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= drain.rd_data;
        end
    end

endmodule

`default_nettype wire

//--- ntt_top.sv
// ntt engine top: input unpacker, butterfly core and output drainer
// CREDITS sets how many beats may be outstanding at the consumer
`default_nettype none

module ntt_top import ntt_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  in_word_t in_data,
    output logic     busy,
    output logic     out_valid,
    output coeff_t   out_data,
    input  logic     credit_return
);

    ntt_load_if  load_bus ();
    ntt_drain_if drain_bus ();

    ntt_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .busy     (busy),
        .load     (load_bus.decode_mp)
    );

    ntt_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_bus.execute_mp),
        .drain (drain_bus.execute_mp)
    );

    ntt_result #(
        .CREDITS (CREDITS)
    ) u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .drain         (drain_bus.result_mp),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// free-running clock for the ntt testbench
// PERIOD sets the full clock period in time units
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb_ntt.sv
// testbench for the ntt engine: loads two frames from the pattern file,
// returns credits after random delays and checks every output beat
// in index order, with a credit stall and junk words during frame 1
`default_nettype none

module tb_ntt import ntt_pkg::*; ();

    localparam int CREDITS      = 4;
    localparam int DRV          = 10;
    localparam int FRAMES       = 2;
    localparam int MAX_DELAY    = 3;
    localparam int STALL_AT     = 40;
    localparam int STALL_CYCLES = 20;
    localparam int JUNK_WORDS   = 30;
    localparam int FRAME_CYCLES = NTT_WORDS + NTT_STAGES * NTT_STEPS + NTT_N * (MAX_DELAY + 2);
    localparam int TIMEOUT_CYCLES = FRAMES * FRAME_CYCLES + STALL_CYCLES + JUNK_WORDS + 200;
    localparam logic [31:0] SEED = 32'h223d9428;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    in_word_t in_data;
    logic     busy;
    logic     out_valid;
    coeff_t   out_data;
    logic     credit_return;

    // per frame: 16 input words, then 16 expected rows
    logic [127:0] patterns [FRAMES * 2 * NTT_WORDS];

    int          errors;
    int          beats;
    int          owed;
    int          returned;
    int          outstanding;
    int          peak_out;

    tb_clock_gen #(.PERIOD(100)) clk_gen_i (.clk(clk));

    ntt_top #(
        .CREDITS (CREDITS)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .busy          (busy),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .credit_return (credit_return)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic coeff_t expected_coeff(input int beat);
        int           frame;
        int           k;
        logic [127:0] row;
        frame = beat / NTT_N;
        k     = beat % NTT_N;
        row   = patterns[frame * 2 * NTT_WORDS + NTT_WORDS + k / NTT_LANES];
        return row[(k % NTT_LANES) * 16 +: 16];
    endfunction

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    // hold the word until an edge sees busy low
    task automatic send_word(input in_word_t word);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_data  = word;
        while (!taken) begin
            @(negedge clk);
            taken = !busy;
            @(posedge clk);
            #DRV;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int frame);
        for (int w = 0; w < NTT_WORDS; w++) begin
            send_word(patterns[frame * 2 * NTT_WORDS + w][31:0]);
        end
    endtask

    // words offered while busy must be dropped by the engine
    task automatic drive_junk();
        for (int i = 0; i < JUNK_WORDS; i++) begin
            in_valid = 1'b1;
            in_data  = $urandom;
            @(negedge clk);
            if (!busy) begin
                errors++;
                $display("junk word offered at %0t while the engine was not busy", $time);
            end
            @(posedge clk);
            #DRV;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // --------------------------------------------------
    // output monitor and credit accounting
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (beats >= FRAMES * NTT_N) begin
                    errors++;
                    $display("extra output beat at %0t after both frames", $time);
                end else begin
                    check_value("out_data", out_data, expected_coeff(beats));
                end
                beats++;
                owed++;
                outstanding++;
            end
            if (credit_return) begin
                outstanding--;
            end
            if (outstanding > CREDITS) begin
                errors++;
                $display("%0d beats outstanding at %0t, more than the %0d credits",
                         outstanding, $time, CREDITS);
            end
            if (outstanding > peak_out) begin
                peak_out = outstanding;
            end
        end
    end

    // one credit back per beat, after a random delay, with one long stall
    initial begin
        int unsigned delay;
        logic        stalled;
        credit_return = 1'b0;
        stalled       = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #DRV;
            credit_return = 1'b0;
            if (returned == STALL_AT && !stalled) begin
                stalled = 1'b1;
                repeat (STALL_CYCLES) @(posedge clk);
                #DRV;
            end
            if (owed > 0) begin
                delay = $urandom_range(MAX_DELAY, 0);
                repeat (delay) @(posedge clk);
                #DRV;
                credit_return = 1'b1;
                owed--;
                returned++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the engine appears to hang with %0d beats",
                 TIMEOUT_CYCLES, beats);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        errors      = 0;
        beats       = 0;
        owed        = 0;
        returned    = 0;
        outstanding = 0;
        peak_out    = 0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        $readmemh("ntt_patterns.hex", patterns);
        if (patterns[NTT_WORDS] == '0) begin
            errors++;
            $display("pattern file is missing or holds no expected rows");
        end

        repeat (8) @(posedge clk);
        #DRV;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        check_value("out_valid", out_valid, 1'b0);

        @(posedge clk);
        #DRV;
        send_frame(0);
        drive_junk();
        wait_idle();
        check_value("frame 1 beats", beats, NTT_N);

        @(posedge clk);
        #DRV;
        send_frame(1);
        wait_idle();
        check_value("frame 2 beats", beats, FRAMES * NTT_N);
        // the stall must have drawn the credits down to zero
        check_value("peak outstanding", peak_out, CREDITS);

        $display("run complete: %0d beats, %0d errors", beats, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ntt_patterns.hex
// per frame: 16 input words (eight nibble coefficients each, nibble 0 first)
// then 16 expected rows of eight 16-bit results, coefficient 0 in the low bits
// frame 1: coefficient 0 = 5, coefficient 64 = 1
00000005
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000001
00000000
00000000
00000000
00000000
00000000
00000000
00000000
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
2a3f2a3f2a3f2a3f2a3f2a3f2a3f2a3f
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
05cc05cc05cc05cc05cc05cc05cc05cc
// frame 2: coefficient 0 = 3, coefficient 32 = 2
00000003
00000000
00000000
00000000
00000002
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
07d007d007d007d007d007d007d007d0
07d007d007d007d007d007d007d007d0
07d007d007d007d007d007d007d007d0
07d007d007d007d007d007d007d007d0
28372837283728372837283728372837
28372837283728372837283728372837
28372837283728372837283728372837
28372837283728372837283728372837
1f991f991f991f991f991f991f991f99
1f991f991f991f991f991f991f991f99
1f991f991f991f991f991f991f991f99
1f991f991f991f991f991f991f991f99
106e106e106e106e106e106e106e106e
106e106e106e106e106e106e106e106e
106e106e106e106e106e106e106e106e
106e106e106e106e106e106e106e106e

//--- sim.f
ntt_pkg.sv
ntt_load_if.sv
ntt_drain_if.sv
ntt_decode.sv
ntt_butterfly.sv
ntt_execute.sv
ntt_result.sv
ntt_top.sv
tb_clock_gen.sv
tb_ntt.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and judge the result from the simulation output
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_ntt -o sim_ntt \
    && ./obj_dir/sim_ntt | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run.sh: pass message found" \
    || { echo "run.sh: pass message not found"; exit 1; }
